// File: hw/cmp_rx_pkg.sv
package cmp_rx_pkg;

	//----------------------------------------
	// Link word and frame geometry
	//----------------------------------------
	localparam int WORD_W      = 16;                    // One word per CMP_RX_CLK160
	localparam int FRAME_WORDS = 3;                     // Data words after the K-word
	localparam int FRAME_W     = FRAME_WORDS * WORD_W;  // Assembled frame
	localparam int KFLAG_W     = WORD_W / 8;            // One flag per byte

	//----------------------------------------
	// K-character codes
	//----------------------------------------
	// Low byte FC in the frame K-word marks a latency trigger
	localparam logic [7:0] LTNCY_K_CHAR = 8'hFC;

	// Bits 4 to 1 of every valid EOF K-byte
	// BC, 1C, 3C ... FC all carry it
	localparam logic [3:0] EOF_NIBBLE = 4'hE;

	//----------------------------------------
	// Link monitor defaults
	//----------------------------------------
	localparam int GOOD_FRAMES_DEF = 16;  // Clean frames before link_good
	localparam int ERR_CNT_W_DEF   = 8;   // Top bit doubles as link_bad

	// Error count holds once its upper nibble gets here
	localparam logic [3:0] ERR_SAT_NIBBLE = 4'hE;

endpackage

// File: hw/cmp_word_qualifier.sv
`timescale 1ns/1ps

module cmp_word_qualifier import cmp_rx_pkg::*; (
	input  logic               CMP_RX_CLK160,
	input  logic               cmp_rx_resetdone,  // Async, active low
	input  logic [WORD_W-1:0]  rx_data,           // Word from the transceiver
	input  logic [KFLAG_W-1:0] rx_isk,            // K flag per byte
	input  logic [KFLAG_W-1:0] rx_notintable,     // Code error per byte
	input  logic               rx_lossofsync,     // Upper loss-of-sync bit
	input  logic               rx_sync_done,      // Phase sync finished
	input  logic               ttc_resync,        // Clears the link status
	output logic [WORD_W-1:0]  q_data,
	output logic               q_sync,            // Frame K-word
	output logic               q_ltrg,            // Frame K-word with FC
	output logic               q_kword_ok,        // Healthy EOF K-word
	output logic               q_data_ok,         // Healthy data word
	output logic               q_clear            // Single registered clear
);

	// Only the low byte is a K-character in the frame marker
	localparam logic [KFLAG_W-1:0] K_LOW_ONLY = KFLAG_W'(1);

	logic k_low;        // Comma pattern on this word
	logic no_code_err;  // In sync and every byte in table

	//----------------------------------------
	// Word decode
	//----------------------------------------
	assign k_low       = (rx_isk == K_LOW_ONLY);
	assign no_code_err = !rx_lossofsync && (rx_notintable == '0);

	// Data path register
	always_ff @(posedge CMP_RX_CLK160) begin
		q_data <= rx_data;
	end

	// Flags line up with q_data
	always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
		if (!cmp_rx_resetdone) begin
			q_sync     <= 1'b0;
			q_ltrg     <= 1'b0;
			q_kword_ok <= 1'b0;
			q_data_ok  <= 1'b0;
			q_clear    <= 1'b0;
		end else begin
			q_sync     <= k_low;
			q_ltrg     <= k_low && (rx_data[7:0] == LTNCY_K_CHAR);  // Trigger marker
			// EOF byte must carry the fixed nibble
			q_kword_ok <= k_low && no_code_err && (rx_data[4:1] == EOF_NIBBLE);
			q_data_ok  <= no_code_err && (rx_isk == '0);  // No K bits in data
			// Only place the clear condition is tested
			q_clear    <= !rx_sync_done || ttc_resync;
		end
	end

	//----------------------------------------
	// Checks
	//----------------------------------------
	a_ltrg_needs_sync: assert property (
		@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
		q_ltrg |-> q_sync
	) else $error("q_ltrg high without q_sync");

endmodule

// File: hw/cmp_frame_assembler.sv
`timescale 1ns/1ps

module cmp_frame_assembler import cmp_rx_pkg::*; (
	input  logic                   CMP_RX_CLK160,
	input  logic                   cmp_rx_resetdone,  // Async, active low
	input  logic [WORD_W-1:0]      q_data,
	input  logic                   q_sync,
	input  logic                   q_ltrg,
	input  logic                   q_kword_ok,
	input  logic                   q_data_ok,
	input  logic                   q_clear,
	output logic [FRAME_W-1:0]     rcv_data,          // {word3, word2, word1}
	output logic [FRAME_WORDS-1:0] nonzero_word,      // Bit 0 is word 1
	output logic                   ltncy_trig,
	output logic                   frame_done,        // Pulse with new rcv_data
	output logic                   frame_good,        // Valid with frame_done
	output logic                   phase_lost         // Open frame lost its phase
);

	logic              cew0;           // K-word slot, frame start
	logic              cew1;           // Word 1 on q_data
	logic              cew2;           // Word 2 on q_data
	logic              cew3;           // Word 3 on q_data
	logic              any_strobe;
	logic              frame_open;     // Set once a frame has started
	logic              ltrg_hold;      // Trigger from frame K-word
	logic              kword_ok_hold;  // K-word health from frame start
	logic              w1_ok;
	logic              w2_ok;
	logic              nz1;
	logic              nz2;
	logic [WORD_W-1:0] w1_reg;
	logic [WORD_W-1:0] w2_reg;

	//----------------------------------------
	// Phase tracking
	//----------------------------------------
	// A K-word only opens a frame outside words 1 to 3
	assign cew0       = q_sync && !(cew1 || cew2 || cew3);
	assign any_strobe = cew0 || cew1 || cew2 || cew3;

	// Holding registers for words 1 and 2
	always_ff @(posedge CMP_RX_CLK160) begin
		if (cew1) w1_reg <= q_data;
		if (cew2) w2_reg <= q_data;
	end

	always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
		if (!cmp_rx_resetdone) begin
			cew1          <= 1'b0;
			cew2          <= 1'b0;
			cew3          <= 1'b0;
			frame_open    <= 1'b0;
			ltrg_hold     <= 1'b0;
			kword_ok_hold <= 1'b0;
			w1_ok         <= 1'b0;
			w2_ok         <= 1'b0;
			nz1           <= 1'b0;
			nz2           <= 1'b0;
			rcv_data      <= '0;
			nonzero_word  <= '0;
			ltncy_trig    <= 1'b0;
			frame_done    <= 1'b0;
			frame_good    <= 1'b0;
			phase_lost    <= 1'b0;
		end else if (q_clear) begin
			cew1          <= 1'b0;       // Wait for a fresh K-word
			cew2          <= 1'b0;
			cew3          <= 1'b0;
			frame_open    <= 1'b0;
			rcv_data      <= '0;
			nonzero_word  <= '0;
			ltncy_trig    <= 1'b0;
			frame_done    <= 1'b0;
			frame_good    <= 1'b0;
			phase_lost    <= 1'b0;
		end else begin
			cew1 <= cew0;  // Phase shift register
			cew2 <= cew1;
			cew3 <= cew2;

			// Latch K-word info at frame start
			if (cew0) begin
				ltrg_hold     <= q_ltrg;
				kword_ok_hold <= q_kword_ok;
			end
			if (cew1) begin
				w1_ok <= q_data_ok;
				nz1   <= |q_data;
			end
			if (cew2) begin
				w2_ok <= q_data_ok;
				nz2   <= |q_data;
			end

			//----------------------------------------
			// Frame output
			//----------------------------------------
			frame_done <= cew3;
			if (cew3) begin
				rcv_data     <= {q_data, w2_reg, w1_reg};
				nonzero_word <= {|q_data, nz2, nz1};
				ltncy_trig   <= ltrg_hold;
				frame_good   <= kword_ok_hold && w1_ok && w2_ok && q_data_ok;
			end else if (!any_strobe) begin
				rcv_data     <= '0;    // Stream broke, drop stale data
				nonzero_word <= '0;
				ltncy_trig   <= 1'b0;
			end

			phase_lost <= frame_open && !any_strobe;  // One pulse per loss
			if (cew0) frame_open <= 1'b1;
			else if (!any_strobe) frame_open <= 1'b0;
		end
	end

	a_one_strobe: assert property (
		@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
		$onehot0({cew1, cew2, cew3})
	) else $error("More than one phase strobe active");

endmodule

// File: hw/cmp_link_monitor.sv
`timescale 1ns/1ps

module cmp_link_monitor import cmp_rx_pkg::*; #(
	parameter int GOOD_FRAMES = GOOD_FRAMES_DEF,  // Clean frames to call the link good
	parameter int ERR_CNT_W   = ERR_CNT_W_DEF     // At least 4 for the saturation nibble
) (
	input  logic                 CMP_RX_CLK160,
	input  logic                 cmp_rx_resetdone,  // Async, active low
	input  logic                 q_clear,
	input  logic                 frame_done,
	input  logic                 frame_good,
	input  logic                 phase_lost,
	output logic                 link_good,
	output logic                 link_had_err,
	output logic [ERR_CNT_W-1:0] err_count,         // Link losses since clear
	output logic                 link_bad
);

	localparam int GC_W = $clog2(GOOD_FRAMES + 1);

	logic [GC_W-1:0] good_cnt;     // Consecutive good frames
	logic            link_err;     // Link went down at least once
	logic            link_proven;  // A frame passed while the link was up
	logic            good_evt;
	logic            bad_evt;
	logic            err_sat;

	//----------------------------------------
	// Frame judgement
	//----------------------------------------
	assign good_evt = frame_done && frame_good;
	assign bad_evt  = (frame_done && !frame_good) || phase_lost;
	assign err_sat  = (err_count[ERR_CNT_W-1 -: 4] == ERR_SAT_NIBBLE);

	always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
		if (!cmp_rx_resetdone) begin
			good_cnt    <= '0;
			link_good   <= 1'b0;
			link_err    <= 1'b0;
			link_proven <= 1'b0;
			err_count   <= '0;
		end else if (q_clear) begin
			good_cnt    <= '0;
			link_good   <= 1'b0;
			link_err    <= 1'b0;
			link_proven <= 1'b0;
			err_count   <= '0;
		end else if (bad_evt) begin
			good_cnt  <= '0;  // Start counting again
			link_good <= 1'b0;
			if (link_good) begin
				link_err <= 1'b1;  // Sticky until clear
				if (!err_sat) err_count <= err_count + 1'b1;
			end
		end else if (good_evt && !link_good) begin
			good_cnt <= good_cnt + 1'b1;
			if (good_cnt == GC_W'(GOOD_FRAMES - 1)) link_good <= 1'b1;
		end else if (good_evt) begin
			link_proven <= 1'b1;  // Count frozen while up
		end
	end

	//----------------------------------------
	// Status outputs
	//----------------------------------------
	// High until a frame passes on a good link, and after any loss
	assign link_had_err = link_err || !link_proven;
	assign link_bad     = err_count[ERR_CNT_W-1];

	a_err_count_monotonic: assert property (
		@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
		!q_clear |=> (err_count >= $past(err_count))
	) else $error("err_count decreased without a clear");

endmodule

// File: hw/cmp_fiber_rx.sv
`timescale 1ns/1ps

module cmp_fiber_rx import cmp_rx_pkg::*; #(
	parameter int GOOD_FRAMES = GOOD_FRAMES_DEF,
	parameter int ERR_CNT_W   = ERR_CNT_W_DEF
) (
	input  logic                   CMP_RX_CLK160,
	input  logic                   cmp_rx_resetdone,  // Async, active low
	input  logic [WORD_W-1:0]      rx_data,
	input  logic [KFLAG_W-1:0]     rx_isk,
	input  logic [KFLAG_W-1:0]     rx_notintable,
	input  logic                   rx_lossofsync,
	input  logic                   rx_sync_done,
	input  logic                   ttc_resync,
	output logic [FRAME_W-1:0]     rcv_data,
	output logic [FRAME_WORDS-1:0] nonzero_word,
	output logic                   ltncy_trig,
	output logic                   link_good,
	output logic                   link_had_err,
	output logic [ERR_CNT_W-1:0]   err_count,
	output logic                   link_bad
);

	logic [WORD_W-1:0] q_data;
	logic              q_sync;
	logic              q_ltrg;
	logic              q_kword_ok;
	logic              q_data_ok;
	logic              q_clear;     // Shared by assembler and monitor
	logic              frame_done;
	logic              frame_good;
	logic              phase_lost;

	//----------------------------------------
	// Word qualifier
	//----------------------------------------
	cmp_word_qualifier u_qualifier (
		.CMP_RX_CLK160    (CMP_RX_CLK160),
		.cmp_rx_resetdone (cmp_rx_resetdone),
		.rx_data          (rx_data),
		.rx_isk           (rx_isk),
		.rx_notintable    (rx_notintable),
		.rx_lossofsync    (rx_lossofsync),
		.rx_sync_done     (rx_sync_done),
		.ttc_resync       (ttc_resync),
		.q_data           (q_data),
		.q_sync           (q_sync),
		.q_ltrg           (q_ltrg),
		.q_kword_ok       (q_kword_ok),
		.q_data_ok        (q_data_ok),
		.q_clear          (q_clear)
	);

	// Frame assembly, 4 edges from K-word to rcv_data
	cmp_frame_assembler u_assembler (
		.CMP_RX_CLK160    (CMP_RX_CLK160),
		.cmp_rx_resetdone (cmp_rx_resetdone),
		.q_data           (q_data),
		.q_sync           (q_sync),
		.q_ltrg           (q_ltrg),
		.q_kword_ok       (q_kword_ok),
		.q_data_ok        (q_data_ok),
		.q_clear          (q_clear),
		.rcv_data         (rcv_data),
		.nonzero_word     (nonzero_word),
		.ltncy_trig       (ltncy_trig),
		.frame_done       (frame_done),
		.frame_good       (frame_good),
		.phase_lost       (phase_lost)
	);

	//----------------------------------------
	// Link status
	//----------------------------------------
	cmp_link_monitor #(
		.GOOD_FRAMES (GOOD_FRAMES),
		.ERR_CNT_W   (ERR_CNT_W)
	) u_monitor (
		.CMP_RX_CLK160    (CMP_RX_CLK160),
		.cmp_rx_resetdone (cmp_rx_resetdone),
		.q_clear          (q_clear),
		.frame_done       (frame_done),
		.frame_good       (frame_good),
		.phase_lost       (phase_lost),
		.link_good        (link_good),
		.link_had_err     (link_had_err),
		.err_count        (err_count),
		.link_bad         (link_bad)
	);

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic CMP_RX_CLK160,
	output logic cmp_rx_resetdone   // Low for the first 3 edges
);

	localparam int HALF_PERIOD = 10;  // 20 ns period
	localparam int RESET_EDGES = 3;

	initial begin
		CMP_RX_CLK160 = 1'b0;
		forever #(HALF_PERIOD) CMP_RX_CLK160 = ~CMP_RX_CLK160;
	end

	// Reset leaves on a rising edge
	initial begin
		cmp_rx_resetdone = 1'b0;
		repeat (RESET_EDGES) @(posedge CMP_RX_CLK160);
		cmp_rx_resetdone <= 1'b1;
	end

endmodule

// File: testbench/tb_cmp_fiber_rx.sv
`timescale 1ns/1ps

module tb_cmp_fiber_rx import cmp_rx_pkg::*; ();

	localparam int ERR_W   = ERR_CNT_W_DEF;
	localparam int N_GOOD  = GOOD_FRAMES_DEF;     // Clean frames for link up
	localparam int N_CAPT  = 6;                   // Frames in the capture test
	localparam int N_LOOPS = 3;                   // Up and down cycles after resync
	// Frames of tests 1 to 5
	localparam int TOTAL_FRAMES = N_CAPT + 2 + (N_GOOD + 1) + (2 * N_GOOD + 1)
		+ (N_GOOD + 2) + N_LOOPS * (N_GOOD + 1);
	localparam int TIMEOUT_CYC = TOTAL_FRAMES * 4 + 200;

	localparam logic [KFLAG_W-1:0] K_LOW  = KFLAG_W'(1);  // Frame marker flags
	localparam logic [KFLAG_W-1:0] K_HIGH = KFLAG_W'(2);  // Spoils a data word
	localparam logic [7:0]         K_PLAIN = 8'hBC;       // EOF K-byte, no trigger

	logic                 CMP_RX_CLK160;
	logic                 cmp_rx_resetdone;
	logic [WORD_W-1:0]    rx_data;
	logic [KFLAG_W-1:0]   rx_isk;
	logic [KFLAG_W-1:0]   rx_notintable;
	logic                 rx_lossofsync;
	logic                 rx_sync_done;
	logic                 ttc_resync;
	logic [FRAME_W-1:0]   rcv_data;
	logic [FRAME_WORDS-1:0] nonzero_word;
	logic                 ltncy_trig;
	logic                 link_good;
	logic                 link_had_err;
	logic [ERR_W-1:0]     err_count;
	logic                 link_bad;

	integer seed = 32'he8bd;
	int     n_checks = 0;
	int     n_errors = 0;
	int     edge_no = 0;      // Edges driven since reset
	int     last_k_edge = 0;  // Edge that drove the latest K-word
	int     cyc_cnt = 0;
	logic   resync_req = 1'b0;

	// Pending checks, in edge order
	int                     fr_due[$];
	logic [FRAME_W-1:0]     fr_data[$];
	logic [FRAME_WORDS-1:0] fr_nz[$];
	logic                   fr_trig[$];
	int                     ln_due[$];
	logic                   ln_good[$];
	logic [ERR_W-1:0]       ln_cnt[$];
	logic                   ln_had[$];

	tb_clock_gen u_clk (
		.CMP_RX_CLK160    (CMP_RX_CLK160),
		.cmp_rx_resetdone (cmp_rx_resetdone)
	);

	cmp_fiber_rx #(
		.GOOD_FRAMES (N_GOOD),
		.ERR_CNT_W   (ERR_W)
	) DUT (
		.CMP_RX_CLK160    (CMP_RX_CLK160),
		.cmp_rx_resetdone (cmp_rx_resetdone),
		.rx_data          (rx_data),
		.rx_isk           (rx_isk),
		.rx_notintable    (rx_notintable),
		.rx_lossofsync    (rx_lossofsync),
		.rx_sync_done     (rx_sync_done),
		.ttc_resync       (ttc_resync),
		.rcv_data         (rcv_data),
		.nonzero_word     (nonzero_word),
		.ltncy_trig       (ltncy_trig),
		.link_good        (link_good),
		.link_had_err     (link_had_err),
		.err_count        (err_count),
		.link_bad         (link_bad)
	);

	//----------------------------------------
	// Helpers
	//----------------------------------------
	function automatic logic [WORD_W-1:0] rand_word();
		return WORD_W'($random(seed));
	endfunction

	task automatic check_val(input string name, input logic [FRAME_W-1:0] got,
		input logic [FRAME_W-1:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	// Frame data 4 edges after K sample, link state one edge later
	task automatic run_due_checks();
		while (fr_due.size() > 0 && fr_due[0] == edge_no) begin
			check_val("rcv_data", rcv_data, fr_data[0]);
			check_val("nonzero_word", nonzero_word, fr_nz[0]);
			check_val("ltncy_trig", ltncy_trig, fr_trig[0]);
			fr_due.delete(0);
			fr_data.delete(0);
			fr_nz.delete(0);
			fr_trig.delete(0);
		end
		while (ln_due.size() > 0 && ln_due[0] == edge_no) begin
			check_val("link_good", link_good, ln_good[0]);
			check_val("err_count", err_count, ln_cnt[0]);
			check_val("link_had_err", link_had_err, ln_had[0]);
			check_val("link_bad", link_bad, ln_cnt[0][ERR_W-1]);  // Counter top bit
			ln_due.delete(0);
			ln_good.delete(0);
			ln_cnt.delete(0);
			ln_had.delete(0);
		end
	endtask

	// One link word per edge, checked at the falling edge
	task automatic send_word(input logic [WORD_W-1:0] data, input logic [KFLAG_W-1:0] isk);
		@(posedge CMP_RX_CLK160);
		rx_data    <= data;
		rx_isk     <= isk;
		ttc_resync <= resync_req;
		edge_no = edge_no + 1;
		@(negedge CMP_RX_CLK160);
		run_due_checks();
	endtask

	task automatic idle_words(input int n);
		repeat (n) send_word('0, '0);  // Breaks the frame phase
	endtask

	task automatic send_frame(input logic [7:0] kbyte, input logic [WORD_W-1:0] w1,
		input logic [WORD_W-1:0] w2, input logic [WORD_W-1:0] w3, input bit spoil);
		logic [WORD_W-1:0] kword;
		kword = rand_word();
		kword[7:0] = kbyte;       // High byte is don't care
		last_k_edge = edge_no + 1;
		fr_due.push_back(last_k_edge + 5);
		fr_data.push_back({w3, w2, w1});
		fr_nz.push_back({(w3 != 0), (w2 != 0), (w1 != 0)});
		fr_trig.push_back(kbyte == LTNCY_K_CHAR);
		send_word(kword, K_LOW);
		send_word(w1, '0);
		send_word(w2, spoil ? K_HIGH : '0);
		send_word(w3, '0);
	endtask

	// Link state once the latest frame has been judged
	task automatic expect_link(input logic good, input logic [ERR_W-1:0] cnt,
		input logic had);
		ln_due.push_back(last_k_edge + 6);
		ln_good.push_back(good);
		ln_cnt.push_back(cnt);
		ln_had.push_back(had);
	endtask

	task automatic send_clean_frames(input int n);
		repeat (n) send_frame(K_PLAIN, rand_word(), rand_word(), rand_word(), 1'b0);
	endtask

	task automatic clear_link();
		idle_words(3);
		resync_req = 1'b1;
		idle_words(2);
		resync_req = 1'b0;
		idle_words(3);
	endtask

	task automatic report_test(input string name, input int err_before);
		if (n_errors == err_before) $display("test %s: ok", name);
		else $display("test %s: failed, %0d errors", name, n_errors - err_before);
	endtask

	//----------------------------------------
	// Directed tests
	//----------------------------------------
	task automatic capture_random_frames();
		logic [WORD_W-1:0] w1;
		logic [WORD_W-1:0] w2;
		logic [WORD_W-1:0] w3;
		int err_before;
		err_before = n_errors;
		for (int f = 0; f < N_CAPT; f++) begin
			w1 = rand_word();
			w2 = (f == 2) ? '0 : rand_word();  // One empty data word
			w3 = rand_word();
			send_frame(K_PLAIN, w1, w2, w3, 1'b0);
		end
		idle_words(3);
		report_test("1 frame capture", err_before);
	endtask

	task automatic compare_trigger_bytes();
		int err_before;
		err_before = n_errors;
		send_frame(LTNCY_K_CHAR, rand_word(), rand_word(), rand_word(), 1'b0);
		send_frame(K_PLAIN, rand_word(), rand_word(), rand_word(), 1'b0);
		idle_words(3);
		report_test("2 latency trigger", err_before);
	endtask

	task automatic raise_link();
		int err_before;
		err_before = n_errors;
		clear_link();
		send_clean_frames(N_GOOD - 1);
		expect_link(1'b0, '0, 1'b1);
		send_clean_frames(1);
		expect_link(1'b1, '0, 1'b1);  // Not yet proven since clear
		send_clean_frames(1);
		expect_link(1'b1, '0, 1'b0);  // Good frame on a good link
		idle_words(3);
		report_test("3 link up", err_before);
	endtask

	task automatic drop_and_restore_link();
		int err_before;
		err_before = n_errors;
		clear_link();
		send_clean_frames(N_GOOD);
		expect_link(1'b1, '0, 1'b1);
		send_frame(K_PLAIN, rand_word(), rand_word(), rand_word(), 1'b1);
		expect_link(1'b0, ERR_W'(1), 1'b1);
		send_clean_frames(N_GOOD);
		expect_link(1'b1, ERR_W'(1), 1'b1);  // Loss stays recorded
		idle_words(3);
		report_test("4 link loss", err_before);
	endtask

	task automatic resync_and_count_losses();
		logic [WORD_W-1:0] kword;
		int err_before;
		err_before = n_errors;
		// Link up with losses on record, stream still running
		send_clean_frames(N_GOOD + 2);
		kword = rand_word();
		kword[7:0] = K_PLAIN;
		resync_req = 1'b1;
		send_word(kword, K_LOW);      // Resync lands on a frame start
		resync_req = 1'b0;
		send_word(rand_word(), '0);
		send_word(rand_word(), '0);   // Clear has taken effect here
		check_val("err_count", err_count, '0);
		check_val("link_good", link_good, 1'b0);
		check_val("rcv_data", rcv_data, '0);
		check_val("link_had_err", link_had_err, 1'b1);
		for (int i = 1; i <= N_LOOPS; i++) begin
			send_clean_frames(N_GOOD);
			expect_link(1'b1, ERR_W'(i - 1), 1'b1);
			send_frame(K_PLAIN, rand_word(), rand_word(), rand_word(), 1'b1);
			expect_link(1'b0, ERR_W'(i), 1'b1);  // One count per loss
		end
		idle_words(3);
		report_test("5 resync clear", err_before);
	endtask

	//----------------------------------------
	// Run control
	//----------------------------------------
	initial begin
		rx_data       = '0;
		rx_isk        = '0;
		rx_notintable = '0;
		rx_lossofsync = 1'b0;
		rx_sync_done  = 1'b1;   // Phase sync already done
		ttc_resync    = 1'b0;
		wait (cmp_rx_resetdone === 1'b1);
		@(negedge CMP_RX_CLK160);
		capture_random_frames();
		compare_trigger_bytes();
		raise_link();
		drop_and_restore_link();
		resync_and_count_losses();
		if (fr_due.size() != 0 || ln_due.size() != 0) begin
			n_errors++;
			$display("Some scheduled frame or link checks never ran");
		end
		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// Watchdog on total cycles
	always @(posedge CMP_RX_CLK160) begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_cnt >= TIMEOUT_CYC) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

endmodule

// File: cmp_fiber_rx.f
hw/cmp_rx_pkg.sv
hw/cmp_word_qualifier.sv
hw/cmp_frame_assembler.sv
hw/cmp_link_monitor.sv
hw/cmp_fiber_rx.sv
testbench/tb_clock_gen.sv
testbench/tb_cmp_fiber_rx.sv
